// ==== alu_params.svh ====
// ALU core parameters
// data width, shift-amount width and the extended adder width

`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// data word width
`define ALU_WIDTH 32

// msb index of a data word, the sign bit
`define ALU_MSB (`ALU_WIDTH - 1)

// shift amount, low bits of operand b
`define ALU_SHAMT_WIDTH 5

// adder width with the carry-in bit below the lsb
`define ALU_EXT_WIDTH 33

// operator encoding width
`define ALU_OP_WIDTH 5

`endif

// ==== alu_pkg.sv ====
// ALU core package
// operator encoding, word types, request/control structs and controller states

`include "alu_params.svh"

package alu_pkg;

  //////////////////////////////////////////////////
  // operators
  //////////////////////////////////////////////////

  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_ROL,
    ALU_ROR,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_LTU,
    ALU_GE,
    ALU_GEU,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // one data word
  typedef logic [`ALU_WIDTH-1:0] alu_word_t;
  // shift amount
  typedef logic [`ALU_SHAMT_WIDTH-1:0] alu_shamt_t;

  // incoming request, 69 bits
  typedef struct packed {
    alu_op_e   operator;
    alu_word_t operand_a;
    alu_word_t operand_b;
  } alu_req_t;

  //////////////////////////////////////////////////
  // decoded control
  //////////////////////////////////////////////////

  // result source
  typedef enum logic [1:0] {
    RES_ADD,
    RES_LOGIC,
    RES_SHIFT,
    RES_CMP
  } alu_res_sel_e;

  // comparison flavour applied to the ge/eq flags
  typedef enum logic [1:0] {
    CMP_EQ,
    CMP_NE,
    CMP_GE,
    CMP_LT
  } alu_cmp_mode_e;

  // bitwise function
  typedef enum logic [1:0] {
    LOGIC_AND,
    LOGIC_OR,
    LOGIC_XOR
  } alu_logic_op_e;

  typedef struct packed {
    logic          adder_negate;
    logic          cmp_signed;
    alu_cmp_mode_e cmp_mode;
    logic          shift_left;
    logic          shift_arith;
    // shift by 32 minus the amount
    logic          shift_compl;
    alu_logic_op_e logic_op;
    alu_res_sel_e  res_sel;
    // load the rotation intermediate register
    logic          imd_we;
    // or the intermediate value into the shift result
    logic          rot_merge;
    // last execute cycle, capture the result
    logic          result_en;
  } alu_ctrl_t;

  // sequencing FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_ROT2
  } alu_state_e;

endpackage

// ==== alu_adder_cmp.sv ====
// ALU adder and comparator
// 33-bit add with carry-in slot, optional negation of operand b,
// signed/unsigned compare derived from the difference

`timescale 1ns/100ps

`include "alu_params.svh"

module alu_adder_cmp import alu_pkg::*; (
  input  alu_ctrl_t ctrl_i,
  input  alu_word_t operand_a_i,
  input  alu_word_t operand_b_i,
  output alu_word_t adder_result_o,
  output logic      cmp_result_o
);

  //////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////

  logic [`ALU_EXT_WIDTH-1:0] adder_in_a;
  logic [`ALU_EXT_WIDTH-1:0] adder_in_b;
  logic [`ALU_EXT_WIDTH-1:0] adder_sum;
  logic                      is_equal;
  logic                      is_ge;

  // lsb of a is a constant one, so an inverted b gets its +1 for free
  assign adder_in_a = {operand_a_i, 1'b1};
  // inverting {b,0} yields {~b,1}, the carry then ripples into bit 1
  assign adder_in_b = ctrl_i.adder_negate ? ~{operand_b_i, 1'b0} : {operand_b_i, 1'b0};

  assign adder_sum      = adder_in_a + adder_in_b;
  // drop the carry-in slot
  assign adder_result_o = adder_sum[`ALU_EXT_WIDTH-1:1];

  //////////////////////////////////////////////////
  // comparison
  //////////////////////////////////////////////////

  // a - b == 0
  assign is_equal = (adder_result_o == '0);

  always_comb begin
    // same msb, the difference cannot overflow so its sign decides
    if (operand_a_i[`ALU_MSB] == operand_b_i[`ALU_MSB]) begin
      is_ge = ~adder_result_o[`ALU_MSB];
    end else begin
      // msbs differ: unsigned a wins if its msb is set, signed is the opposite
      is_ge = operand_a_i[`ALU_MSB] ^ ctrl_i.cmp_signed;
    end
  end

  always_comb begin
    unique case (ctrl_i.cmp_mode)
      CMP_EQ:  cmp_result_o = is_equal;
      CMP_NE:  cmp_result_o = ~is_equal;
      CMP_GE:  cmp_result_o = is_ge;
      CMP_LT:  cmp_result_o = ~is_ge;
      default: cmp_result_o = is_equal;
    endcase
  end

endmodule

// ==== alu_shifter.sv ====
// ALU shifter
// one 33-bit arithmetic right shifter, left shifts go through bit reversal
// before and after, rotations use it twice with plain and complement amounts

`timescale 1ns/100ps

`include "alu_params.svh"

module alu_shifter import alu_pkg::*; (
  input  alu_ctrl_t ctrl_i,
  input  alu_word_t operand_a_i,
  input  alu_word_t operand_b_i,
  output alu_word_t shift_result_o
);

  alu_shamt_t                 shamt;
  logic [`ALU_SHAMT_WIDTH:0]  shamt_compl;
  alu_word_t                  operand_a_rev;
  alu_word_t                  shift_in;
  logic [`ALU_WIDTH:0]        shift_ext;
  alu_word_t                  shift_out;

  //////////////////////////////////////////////////
  // shift amount
  //////////////////////////////////////////////////

  // 32 - amount, only the low bits are kept so amount 0 stays 0
  assign shamt_compl = (`ALU_SHAMT_WIDTH+1)'(`ALU_WIDTH)
                     - {1'b0, operand_b_i[`ALU_SHAMT_WIDTH-1:0]};

  assign shamt = ctrl_i.shift_compl ? shamt_compl[`ALU_SHAMT_WIDTH-1:0]
                                    : operand_b_i[`ALU_SHAMT_WIDTH-1:0];

  //////////////////////////////////////////////////
  // input reversal
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : gen_rev_a
    assign operand_a_rev[i] = operand_a_i[`ALU_MSB-i];
  end

  assign shift_in = ctrl_i.shift_left ? operand_a_rev : operand_a_i;

  //////////////////////////////////////////////////
  // right shift and output reversal
  //////////////////////////////////////////////////

  always_comb begin
    // extension bit carries the sign for sra, zero otherwise
    shift_ext = $signed({ctrl_i.shift_arith & shift_in[`ALU_MSB], shift_in}) >>> shamt;
    shift_out = shift_ext[`ALU_WIDTH-1:0];

    if (ctrl_i.shift_left) begin
      // swap neighbouring bits, then pairs, nibbles, bytes and halves
      shift_out = ((shift_out & 32'h5555_5555) << 1)
                | ((shift_out & 32'haaaa_aaaa) >> 1);
      shift_out = ((shift_out & 32'h3333_3333) << 2)
                | ((shift_out & 32'hcccc_cccc) >> 2);
      shift_out = ((shift_out & 32'h0f0f_0f0f) << 4)
                | ((shift_out & 32'hf0f0_f0f0) >> 4);
      shift_out = ((shift_out & 32'h00ff_00ff) << 8)
                | ((shift_out & 32'hff00_ff00) >> 8);
      shift_out = ((shift_out & 32'h0000_ffff) << 16)
                | ((shift_out & 32'hffff_0000) >> 16);
    end
  end

  assign shift_result_o = shift_out;

endmodule

// ==== alu_result_sel.sv ====
// ALU result stage
// bitwise logic, rotation intermediate register, result mux and
// the registered result with its valid pulse

`timescale 1ns/100ps

`include "alu_params.svh"

module alu_result_sel import alu_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  alu_ctrl_t ctrl_i,
  input  alu_word_t operand_a_i,
  input  alu_word_t operand_b_i,
  input  alu_word_t adder_result_i,
  input  logic      cmp_result_i,
  input  alu_word_t shift_result_i,
  output alu_word_t result_o,
  output logic      result_valid_o
);

  alu_word_t logic_result;
  alu_word_t imd_q;
  alu_word_t rot_result;
  alu_word_t result_d;
  alu_word_t result_q;
  logic      result_valid_q;

  //////////////////////////////////////////////////
  // bitwise logic
  //////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl_i.logic_op)
      LOGIC_AND: logic_result = operand_a_i & operand_b_i;
      LOGIC_OR:  logic_result = operand_a_i | operand_b_i;
      default:   logic_result = operand_a_i ^ operand_b_i;
    endcase
  end

  // first rotation half, kept until the second cycle
  always_ff @(posedge clk_i) begin
    if (ctrl_i.imd_we) begin
      imd_q <= shift_result_i;
    end
  end

  // second half merged in, both halves cover disjoint bits
  assign rot_result = ctrl_i.rot_merge ? (shift_result_i | imd_q) : shift_result_i;

  //////////////////////////////////////////////////
  // result mux and register
  //////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl_i.res_sel)
      RES_ADD:   result_d = adder_result_i;
      RES_LOGIC: result_d = logic_result;
      RES_SHIFT: result_d = rot_result;
      default:   result_d = {{(`ALU_WIDTH-1){1'b0}}, cmp_result_i};
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_q       <= '0;
      result_valid_q <= 1'b0;
    end else begin
      // valid is high only in the cycle after the last execute cycle
      result_valid_q <= ctrl_i.result_en;
      if (ctrl_i.result_en) begin
        result_q <= result_d;
      end
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;

endmodule

// ==== alu_ctrl.sv ====
// ALU controller
// captures a request, decodes the operator into datapath control and
// steps one execute cycle, or two for rotations

`timescale 1ns/100ps

module alu_ctrl import alu_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  input  alu_req_t  req_i,
  output logic      busy_o,
  output alu_ctrl_t ctrl_o,
  output alu_word_t operand_a_o,
  output alu_word_t operand_b_o
);

  alu_state_e state_q;
  alu_state_e state_d;
  alu_req_t   req_q;
  logic       accept;
  logic       is_rot;
  logic       first_cycle;
  logic       last_cycle;

  //////////////////////////////////////////////////
  // request register
  //////////////////////////////////////////////////

  // requests arriving while busy are dropped
  assign accept = req_valid_i && (state_q == ST_IDLE);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  assign operand_a_o = req_q.operand_a;
  assign operand_b_o = req_q.operand_b;

  //////////////////////////////////////////////////
  // sequencing FSM
  //////////////////////////////////////////////////

  assign is_rot      = (req_q.operator == ALU_ROL) || (req_q.operator == ALU_ROR);
  assign first_cycle = (state_q == ST_EXEC);
  assign last_cycle  = is_rot ? (state_q == ST_ROT2) : first_cycle;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: if (accept) state_d = ST_EXEC;
      ST_EXEC: state_d = is_rot ? ST_ROT2 : ST_IDLE;
      ST_ROT2: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign busy_o = (state_q != ST_IDLE);

  //////////////////////////////////////////////////
  // operator decode
  //////////////////////////////////////////////////

  always_comb begin
    ctrl_o = '0;
    // everything stays quiet while idle
    if (busy_o) begin
      ctrl_o.result_en = last_cycle;
      unique case (req_q.operator)
        ALU_ADD: ctrl_o.res_sel = RES_ADD;
        ALU_SUB: begin
          ctrl_o.adder_negate = 1'b1;
          ctrl_o.res_sel      = RES_ADD;
        end
        ALU_AND: ctrl_o.res_sel = RES_LOGIC;
        ALU_OR: begin
          ctrl_o.logic_op = LOGIC_OR;
          ctrl_o.res_sel  = RES_LOGIC;
        end
        ALU_XOR: begin
          ctrl_o.logic_op = LOGIC_XOR;
          ctrl_o.res_sel  = RES_LOGIC;
        end
        ALU_SLL: begin
          ctrl_o.shift_left = 1'b1;
          ctrl_o.res_sel    = RES_SHIFT;
        end
        ALU_SRL: ctrl_o.res_sel = RES_SHIFT;
        ALU_SRA: begin
          ctrl_o.shift_arith = 1'b1;
          ctrl_o.res_sel     = RES_SHIFT;
        end
        // rol: a << b first, then a >> (32 - b); ror the other way round
        ALU_ROL, ALU_ROR: begin
          ctrl_o.shift_left  = (req_q.operator == ALU_ROL) ? first_cycle : !first_cycle;
          ctrl_o.shift_compl = !first_cycle;
          ctrl_o.imd_we      = first_cycle;
          ctrl_o.rot_merge   = !first_cycle;
          ctrl_o.res_sel     = RES_SHIFT;
        end
        default: begin
          // comparisons, all use a - b
          ctrl_o.adder_negate = 1'b1;
          ctrl_o.res_sel      = RES_CMP;
          ctrl_o.cmp_signed   = (req_q.operator == ALU_LT) || (req_q.operator == ALU_GE)
                             || (req_q.operator == ALU_SLT);
          unique case (req_q.operator)
            ALU_EQ:          ctrl_o.cmp_mode = CMP_EQ;
            ALU_NE:          ctrl_o.cmp_mode = CMP_NE;
            ALU_GE, ALU_GEU: ctrl_o.cmp_mode = CMP_GE;
            default:         ctrl_o.cmp_mode = CMP_LT;
          endcase
        end
      endcase
    end
  end

endmodule

// ==== alu_core.sv ====
// ALU core top level
// controller plus adder/comparator, shifter and result stage

`timescale 1ns/100ps

module alu_core import alu_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  input  alu_req_t  req_i,
  output logic      busy_o,
  output logic      result_valid_o,
  output alu_word_t result_o
);

  alu_ctrl_t ctrl;
  alu_word_t operand_a;
  alu_word_t operand_b;
  alu_word_t adder_result;
  logic      cmp_result;
  alu_word_t shift_result;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  alu_ctrl u_alu_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .ctrl_o      (ctrl),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b)
  );

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  alu_adder_cmp u_alu_adder_cmp (
    .ctrl_i         (ctrl),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .adder_result_o (adder_result),
    .cmp_result_o   (cmp_result)
  );

  alu_shifter u_alu_shifter (
    .ctrl_i         (ctrl),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .shift_result_o (shift_result)
  );

  // registered result and valid pulse
  alu_result_sel u_alu_result_sel (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .ctrl_i         (ctrl),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .adder_result_i (adder_result),
    .cmp_result_i   (cmp_result),
    .shift_result_i (shift_result),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

// ==== tb_alu_model.svh ====
// ALU reference model for the testbench
// expected results worked out from the operator definitions

`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// comparison flag as a zero-extended word
function automatic alu_word_t flag_word(input bit flag);
  flag_word = '0;
  flag_word[0] = flag;
endfunction

// bit i of a moves up to bit i+sh, wrapping around the word
function automatic alu_word_t rotate_left(input alu_word_t a, input int sh);
  alu_word_t r;
  r = '0;
  for (int i = 0; i < `ALU_WIDTH; i++) begin
    r[(i + sh) % `ALU_WIDTH] = a[i];
  end
  return r;
endfunction

function automatic alu_word_t expected_result(input alu_op_e op, input alu_word_t a,
                                              input alu_word_t b);
  int sh;
  alu_word_t r;
  // only the low five bits of b count as shift amount
  sh = b[`ALU_SHAMT_WIDTH-1:0];
  case (op)
    ALU_ADD:  r = a + b;
    ALU_SUB:  r = a - b;
    ALU_XOR:  r = a ^ b;
    ALU_OR:   r = a | b;
    ALU_AND:  r = a & b;
    ALU_SLL:  r = a << sh;
    ALU_SRL:  r = a >> sh;
    ALU_SRA:  r = $signed(a) >>> sh;
    ALU_ROL:  r = rotate_left(a, sh);
    // right by sh is left by the remaining distance
    ALU_ROR:  r = rotate_left(a, (`ALU_WIDTH - sh) % `ALU_WIDTH);
    ALU_EQ:   r = flag_word(a == b);
    ALU_NE:   r = flag_word(a != b);
    ALU_LT:   r = flag_word($signed(a) < $signed(b));
    ALU_LTU:  r = flag_word(a < b);
    ALU_GE:   r = flag_word($signed(a) >= $signed(b));
    ALU_GEU:  r = flag_word(a >= b);
    ALU_SLT:  r = flag_word($signed(a) < $signed(b));
    default:  r = flag_word(a < b);
  endcase
  return r;
endfunction

`endif

// ==== tb_alu_core.sv ====
// ALU core testbench
// directed corner operands and seeded random operands through every operator,
// with latency, busy and valid-pulse checks

`timescale 1ns/100ps

`include "alu_params.svh"

module tb_alu_core import alu_pkg::*; ;

  `include "tb_alu_model.svh"

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DLY      = 2;
  localparam int TIMEOUT_CYCLES = 20;
  localparam int NUM_OPS        = 18;
  localparam int RANDOM_ROUNDS  = 8;

  logic      clk;
  logic      arst_n;
  logic      req_valid;
  alu_req_t  req;
  logic      busy;
  logic      result_valid;
  alu_word_t result;

  int        value_errors;
  int        protocol_errors;
  int        timeouts;
  bit        timed_out;
  int        pulse_count;
  int        result_count;
  logic      prev_valid;
  integer    seed;

  // corner operand pairs, equal values, mixed signs and the shift amounts 0 and 31
  alu_word_t corner_a [8] = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000,
                              32'h7fff_ffff, 32'h1234_5678, 32'h8765_4321, 32'hf0f0_0f0f};
  alu_word_t corner_b [8] = '{32'h0000_0000, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000,
                              32'h8000_0000, 32'h0000_0000, 32'h0000_001f, 32'hffff_ffe3};

  alu_core u_alu_core (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .busy_o         (busy),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // valid pulse monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (arst_n) begin
      if (result_valid) begin
        pulse_count++;
        // one cycle wide, and the core is idle again
        assert (!prev_valid && !busy) else begin
          protocol_errors++;
          $display("error at %0t: valid pulse too long or busy still high", $time);
        end
      end
      prev_valid = result_valid;
    end
  end

  //////////////////////////////////////////////////
  // one request through the core
  //////////////////////////////////////////////////

  task automatic run_op(input alu_op_e op, input alu_word_t a, input alu_word_t b,
                        input bit inject);
    alu_word_t expected;
    int        latency;
    int        cycles;
    if (timed_out) return;
    expected = expected_result(op, a, b);
    // rotations take one extra execute cycle
    latency  = (op == ALU_ROL || op == ALU_ROR) ? 2 : 1;
    cycles   = 0;
    while (busy && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    if (busy) begin
      timeouts++;
      timed_out = 1'b1;
      $display("timeout: core stayed busy before %s could be issued", op.name());
      return;
    end
    req_valid = 1'b1;
    req       = '{operator: op, operand_a: a, operand_b: b};
    // acceptance edge
    @(posedge clk);
    #DRIVE_DLY;
    req_valid = 1'b0;
    if (inject) begin
      // a different request held through every busy cycle, must be dropped
      req_valid = 1'b1;
      req       = '{operator: (op == ALU_XOR) ? ALU_ADD : ALU_XOR, operand_a: ~a,
                    operand_b: b + 32'h1};
    end
    cycles = 0;
    while (!result_valid && cycles < TIMEOUT_CYCLES) begin
      assert (busy) else begin
        protocol_errors++;
        $display("error at %0t: busy low while %s executes", $time, op.name());
      end
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    req_valid = 1'b0;
    if (!result_valid) begin
      timeouts++;
      timed_out = 1'b1;
      $display("timeout: no result valid for %s", op.name());
      return;
    end
    result_count++;
    assert (cycles == latency && !busy) else begin
      protocol_errors++;
      $display("error at %0t: %s result after %0d cycles, expected %0d", $time, op.name(),
               cycles, latency);
    end
    assert (result === expected) else begin
      value_errors++;
      $display("error at %0t: %s a=%h b=%h gave %h, expected %h", $time, op.name(), a, b,
               result, expected);
    end
    // result holds and no second pulse follows
    @(posedge clk);
    #DRIVE_DLY;
    assert (result === expected && !result_valid && !busy) else begin
      protocol_errors++;
      $display("error at %0t: %s result not held or extra activity", $time, op.name());
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    arst_n          = 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    value_errors    = 0;
    protocol_errors = 0;
    timeouts        = 0;
    timed_out       = 1'b0;
    pulse_count     = 0;
    result_count    = 0;
    prev_valid      = 1'b0;
    seed            = 74;

    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    // outputs quiet out of reset, before any request
    repeat (2) begin
      assert (!busy && !result_valid && result === '0) else begin
        protocol_errors++;
        $display("error at %0t: outputs not zero after reset", $time);
      end
      @(posedge clk);
      #DRIVE_DLY;
    end

    // every operator on every corner pair
    for (int p = 0; p < 8; p++) begin
      for (int k = 0; k < NUM_OPS; k++) begin
        run_op(alu_op_e'(k), corner_a[p], corner_b[p], p == 3);
      end
    end

    // seeded random operands, every other one with a dropped request
    for (int r = 0; r < RANDOM_ROUNDS; r++) begin
      for (int k = 0; k < NUM_OPS; k++) begin
        run_op(alu_op_e'(k), $random(seed), $random(seed), (r % 2) == 1);
      end
    end

    assert (pulse_count == result_count) else begin
      protocol_errors++;
      $display("error at %0t: %0d valid pulses for %0d results", $time, pulse_count,
               result_count);
    end

    $display("%0d results, %0d value errors, %0d protocol errors, %0d timeouts",
             result_count, value_errors, protocol_errors, timeouts);
    if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
alu_pkg.sv
alu_adder_cmp.sv
alu_shifter.sv
alu_result_sel.sv
alu_ctrl.sv
alu_core.sv
tb_alu_core.sv

// ==== Bender.yml ====
package:
  name: alu_core

export_include_dirs:
  - .

sources:
  - alu_pkg.sv
  - alu_adder_cmp.sv
  - alu_shifter.sv
  - alu_result_sel.sv
  - alu_ctrl.sv
  - alu_core.sv
  - target: test
    files:
      - tb_alu_core.sv
